//--- verilog/sdram_pkg.sv
// shared widths, SDRAM timing and command/state encodings for the controller
// compile before any module; modules pull it in with a wildcard import
package sdram_pkg;

    // wishbone word address, top to bottom: bank | row | column
    localparam int BANK_W = 2;
    localparam int ROW_W  = 12;
    localparam int COL_W  = 8;
    localparam int WB_AW  = BANK_W + ROW_W + COL_W;   // 22 bit word address
    localparam int DW     = 16;                       // one SDRAM word
    localparam int NBANK  = 4;
    localparam int SA_W   = 13;                       // address pins, A12..A0

    // timing in clock cycles
    localparam int T_RP    = 2;    // precharge to activate
    localparam int T_RCD   = 2;    // activate to read/write
    localparam int T_RRD   = 2;    // activate to activate, any bank
    localparam int CAS_LAT = 2;    // read command to data on dq

    // small counters for the waits above, 2 bits covers all of them
    localparam int TCNT_W = 2;

    // request queue
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_AW    = 2;  // log2 of the depth

    // bit order is /CS /RAS /CAS /WE, so the value goes straight to the pins
    typedef enum logic [3:0] {
        CMD_PRECHARGE = 4'b0010,
        CMD_ACTIVE    = 4'b0011,
        CMD_WRITE     = 4'b0100,
        CMD_READ      = 4'b0101,
        CMD_NOP       = 4'b0111
    } sdram_cmd_e;

    // per bank sequencing
    typedef enum logic [1:0] {
        IDLE,          // waiting for a request, decides prech/act/access
        PRECH_WAIT,    // counting tRP
        ACT_WAIT,      // counting tRCD
        ISSUE          // row open, waiting for the bus to send READ/WRITE
    } bank_state_e;

endpackage

//--- verilog/sdram_wb_port.sv
`timescale 1ns/1ps
// wishbone classic slave side of the controller
// pushes one request per bus cycle into the queue, acks writes once queued
// and reads when their data comes back from the sequencer
module sdram_wb_port (
    input  logic                        clk,
    input  logic                        rst,
    // wishbone classic
    input  logic                        wb_cyc,
    input  logic                        wb_stb,
    input  logic                        wb_we,
    input  logic [sdram_pkg::WB_AW-1:0] wb_adr,
    input  logic [sdram_pkg::DW-1:0]    wb_dat_w,
    output logic                        wb_ack,
    output logic [sdram_pkg::DW-1:0]    wb_dat_r,
    // request queue
    output logic                        push,
    output logic                        push_we,
    output logic [sdram_pkg::WB_AW-1:0] push_adr,
    output logic [sdram_pkg::DW-1:0]    push_dat,
    input  logic                        full,
    // read return
    input  logic                        rd_valid,
    input  logic [sdram_pkg::DW-1:0]    rd_data
);

    logic busy;      // current bus cycle already queued, waiting for its ack
    logic rd_wait;   // queued request is a read, ack comes with the data
    logic taken;     // queue accepts the push this cycle

    // master holds everything until ack, so forward it as is
    assign push     = wb_cyc && wb_stb && !busy;
    assign push_we  = wb_we;
    assign push_adr = wb_adr;
    assign push_dat = wb_dat_w;
    assign taken    = push && !full;    // full queue stalls the ack

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy    <= 1'b0;
            rd_wait <= 1'b0;
            wb_ack  <= 1'b0;
        end else begin
            wb_ack <= 1'b0;               // single cycle pulse
            if (taken) begin
                busy    <= 1'b1;
                rd_wait <= !wb_we;
                wb_ack  <= wb_we;         // posted write, ack right away
            end
            if (rd_wait && rd_valid) begin
                rd_wait <= 1'b0;
                wb_ack  <= 1'b1;
            end
            // stb is still up during the ack cycle, so release only after it
            if (wb_ack) begin
                busy <= 1'b0;
            end
        end
    end

    // read data register, loaded with the returning word
    always_ff @(posedge clk) begin
        if (rd_wait && rd_valid) begin
            wb_dat_r <= rd_data;
        end
    end

endmodule

//--- verilog/sdram_req_fifo.sv
`timescale 1ns/1ps
// in-order request queue between the wishbone port and the sequencer
// the head is visible whenever empty is low, pop drops it at the clock edge
module sdram_req_fifo (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        push,
    input  logic                        push_we,
    input  logic [sdram_pkg::WB_AW-1:0] push_adr,
    input  logic [sdram_pkg::DW-1:0]    push_dat,
    output logic                        full,
    input  logic                        pop,
    output logic                        empty,
    output logic                        head_we,
    output logic [sdram_pkg::WB_AW-1:0] head_adr,
    output logic [sdram_pkg::DW-1:0]    head_dat
);
    import sdram_pkg::*;

    logic             mem_we  [FIFO_DEPTH];
    logic [WB_AW-1:0] mem_adr [FIFO_DEPTH];
    logic [DW-1:0]    mem_dat [FIFO_DEPTH];

    logic [FIFO_AW-1:0] wr_ptr, rd_ptr;    // wrap on their own since the depth is 2^n
    logic [FIFO_AW:0]   count;
    logic               do_push, do_pop;

    assign full    = count == (FIFO_AW+1)'(FIFO_DEPTH);
    assign empty   = count == '0;
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;        // both at once keeps count

    assign head_we  = mem_we[rd_ptr];
    assign head_adr = mem_adr[rd_ptr];
    assign head_dat = mem_dat[rd_ptr];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop)      count <= count + 1'b1;
            else if (do_pop && !do_push) count <= count - 1'b1;
        end
    end

    // entry storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_we[wr_ptr]  <= push_we;
            mem_adr[wr_ptr] <= push_adr;
            mem_dat[wr_ptr] <= push_dat;
        end
    end

endmodule

//--- verilog/sdram_bank.sv
`timescale 1ns/1ps
// one SDRAM bank: tracks its open row and sequences PRECHARGE, ACTIVE, READ/WRITE
// requests for the bus with br and only drives cmd/sa during the granted cycle
module sdram_bank (
    input  logic                        clk,
    input  logic                        rst,
    // request from the sequencer, held until issued
    input  logic                        req,
    input  logic                        req_we,
    input  logic [sdram_pkg::ROW_W-1:0] req_row,
    input  logic [sdram_pkg::COL_W-1:0] req_col,
    // shared bus
    input  logic                        bg,          // grant, combinational
    input  logic                        act_block,   // tRRD still running
    output logic                        br,
    output logic                        issued,
    output sdram_pkg::sdram_cmd_e       cmd,
    output logic [sdram_pkg::SA_W-1:0]  sa
);
    import sdram_pkg::*;

    bank_state_e       st;
    logic              actd;        // bank has an open row
    logic [ROW_W-1:0]  row;         // which row is open
    logic [TCNT_W-1:0] cnt;         // tRP / tRCD countdown
    logic              row_hit;
    logic              go;          // asking and granted
    logic              do_prech;
    logic              do_act;
    logic              do_access;

    assign row_hit = actd && (row == req_row);

    // what happens this cycle, all of it needs the grant
    always_comb begin
        br        = 1'b0;
        go        = 1'b0;
        do_prech  = 1'b0;
        do_act    = 1'b0;
        do_access = 1'b0;
        case (st)
            IDLE: begin
                br       = req;
                go       = req && bg;
                do_prech = go && actd && !row_hit;     // wrong row open
                do_act   = go && !actd && !act_block;  // closed, wait out tRRD
            end
            ISSUE: begin
                br        = req;
                go        = req && bg;
                do_access = go;
            end
            default: begin
                br = 1'b0;    // counting, bus not needed
            end
        endcase
    end

    // state and wait counter
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st   <= IDLE;
            actd <= 1'b0;
            cnt  <= '0;
        end else begin
            case (st)
                IDLE: begin
                    if (do_prech) begin
                        st   <= PRECH_WAIT;
                        actd <= 1'b0;
                        cnt  <= TCNT_W'(T_RP - 1);
                    end else if (do_act) begin
                        st   <= ACT_WAIT;
                        actd <= 1'b1;
                        cnt  <= TCNT_W'(T_RCD - 1);
                    end else if (go && row_hit) begin
                        st <= ISSUE;    // hit, command goes out next cycle
                    end
                end
                PRECH_WAIT: begin
                    // back to IDLE, which then opens the new row
                    if (cnt > TCNT_W'(1)) begin
                        cnt <= cnt - 1'b1;
                    end else begin
                        st <= IDLE;
                    end
                end
                ACT_WAIT: begin
                    if (cnt > TCNT_W'(1)) begin
                        cnt <= cnt - 1'b1;
                    end else begin
                        st <= ISSUE;
                    end
                end
                ISSUE: begin
                    if (do_access) begin
                        st <= IDLE;     // burst of 1, nothing left to do
                    end
                end
                default: st <= IDLE;
            endcase
        end
    end

    // open row, only meaningful while actd is set
    always_ff @(posedge clk) begin
        if (do_act) begin
            row <= req_row;
        end
    end

    // command and address, NOP/zero unless granted so the sequencer can OR them
    always_comb begin
        cmd    = CMD_NOP;
        sa     = '0;
        issued = 1'b0;
        if (do_prech) begin
            cmd = CMD_PRECHARGE;    // A10 low, this bank only
        end else if (do_act) begin
            cmd = CMD_ACTIVE;
            sa  = SA_W'(req_row);
        end else if (do_access) begin
            cmd    = req_we ? CMD_WRITE : CMD_READ;
            sa     = SA_W'(req_col);  // A10 low, no auto precharge
            issued = 1'b1;
        end
    end

endmodule

//--- verilog/sdram_cmd_seq.sv
`timescale 1ns/1ps
// command sequencer: hands the queue head to its bank, grants the shared bus,
// merges bank commands onto the pins, keeps tRRD and collects read data
module sdram_cmd_seq (
    input  logic                                            clk,
    input  logic                                            rst,
    // queue head
    input  logic                                            empty,
    input  logic                                            head_we,
    input  logic [sdram_pkg::WB_AW-1:0]                     head_adr,
    input  logic [sdram_pkg::DW-1:0]                        head_dat,
    output logic                                            pop,
    // per bank requests
    output logic [sdram_pkg::NBANK-1:0]                     req,
    output logic [sdram_pkg::NBANK-1:0]                     req_we,
    output logic [sdram_pkg::NBANK-1:0][sdram_pkg::ROW_W-1:0] req_row,
    output logic [sdram_pkg::NBANK-1:0][sdram_pkg::COL_W-1:0] req_col,
    input  logic [sdram_pkg::NBANK-1:0]                     br,
    input  logic [sdram_pkg::NBANK-1:0]                     issued,
    input  sdram_pkg::sdram_cmd_e                           cmd [sdram_pkg::NBANK],
    input  logic [sdram_pkg::NBANK-1:0][sdram_pkg::SA_W-1:0] sa,
    output logic [sdram_pkg::NBANK-1:0]                     bg,
    output logic                                            act_block,
    // SDRAM pins
    output sdram_pkg::sdram_cmd_e                           sdram_cmd,
    output logic [sdram_pkg::BANK_W-1:0]                    sdram_ba,
    output logic [sdram_pkg::SA_W-1:0]                      sdram_a,
    output logic [sdram_pkg::DW-1:0]                        dq_out,
    output logic                                            dq_oe,
    input  logic [sdram_pkg::DW-1:0]                        dq_in,
    // read return to the port
    output logic                                            rd_valid,
    output logic [sdram_pkg::DW-1:0]                        rd_data
);
    import sdram_pkg::*;

    logic [BANK_W-1:0]  head_bank;
    logic [ROW_W-1:0]   head_row;
    logic [COL_W-1:0]   head_col;
    logic [TCNT_W-1:0]  rrd_cnt;     // cycles left before the next ACTIVE
    logic [CAS_LAT-1:0] rd_pipe;     // one bit per cycle since READ
    logic               rd_busy;
    logic [3:0]         cmd_x;       // merged commands, relative to NOP

    // address split, bank on top
    assign head_bank = head_adr[WB_AW-1 -: BANK_W];
    assign head_row  = head_adr[COL_W +: ROW_W];
    assign head_col  = head_adr[COL_W-1:0];
    assign rd_busy   = |rd_pipe;
    assign act_block = rrd_cnt != '0;

    // only the head's bank sees req, so at most one grant at a time
    always_comb begin
        for (int i = 0; i < NBANK; i++) begin
            req[i]     = !empty && (head_bank == BANK_W'(i));
            req_we[i]  = head_we;
            req_row[i] = head_row;
            req_col[i] = head_col;
            // hold writes back until read data is off dq
            bg[i]      = req[i] && br[i] && !(head_we && rd_busy);
        end
    end

    assign pop = |issued;    // head leaves in the cycle its command goes out

    // idle banks output NOP, active low pins, so OR the difference from NOP
    always_comb begin
        cmd_x    = '0;
        sdram_a  = '0;
        sdram_ba = '0;
        for (int i = 0; i < NBANK; i++) begin
            cmd_x   = cmd_x | (cmd[i] ^ CMD_NOP);
            sdram_a = sdram_a | sa[i];
            if (bg[i]) sdram_ba = sdram_ba | BANK_W'(i);
        end
        sdram_cmd = sdram_cmd_e'(cmd_x ^ CMD_NOP);
    end

    // write data goes out with the WRITE command
    assign dq_oe  = sdram_cmd == CMD_WRITE;
    assign dq_out = head_dat;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rrd_cnt  <= '0;
            rd_pipe  <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (sdram_cmd == CMD_ACTIVE) rrd_cnt <= TCNT_W'(T_RRD - 1);
            else if (act_block)          rrd_cnt <= rrd_cnt - 1'b1;
            rd_pipe  <= {rd_pipe[CAS_LAT-2:0], sdram_cmd == CMD_READ};
            rd_valid <= rd_pipe[CAS_LAT-1];    // CAS_LAT+1 after READ
        end
    end

    // sample dq in the CAS latency cycle
    always_ff @(posedge clk) begin
        if (rd_pipe[CAS_LAT-1]) begin
            rd_data <= dq_in;
        end
    end

endmodule

//--- verilog/sdram_ctrl_top.sv
`timescale 1ns/1ps
// SDRAM controller top: wishbone port, request queue, four banks, sequencer
// connect the wishbone side to the bus master and the pins to the SDRAM
module sdram_ctrl_top (
    input  logic                         clk,
    input  logic                         rst,
    // wishbone classic slave
    input  logic                         wb_cyc,
    input  logic                         wb_stb,
    input  logic                         wb_we,
    input  logic [sdram_pkg::WB_AW-1:0]  wb_adr,
    input  logic [sdram_pkg::DW-1:0]     wb_dat_w,
    output logic                         wb_ack,
    output logic [sdram_pkg::DW-1:0]     wb_dat_r,
    // SDRAM, dqm held low outside
    output sdram_pkg::sdram_cmd_e        sdram_cmd,
    output logic [sdram_pkg::BANK_W-1:0] sdram_ba,
    output logic [sdram_pkg::SA_W-1:0]   sdram_a,
    output logic [sdram_pkg::DW-1:0]     dq_out,
    output logic                         dq_oe,
    input  logic [sdram_pkg::DW-1:0]     dq_in
);
    import sdram_pkg::*;

    // port to queue
    logic             push, push_we, full;
    logic [WB_AW-1:0] push_adr;
    logic [DW-1:0]    push_dat;
    // queue to sequencer
    logic             empty, head_we, pop;
    logic [WB_AW-1:0] head_adr;
    logic [DW-1:0]    head_dat;
    // read return
    logic             rd_valid;
    logic [DW-1:0]    rd_data;
    // sequencer to banks
    logic [NBANK-1:0]            req, req_we, br, bg, issued;
    logic [NBANK-1:0][ROW_W-1:0] req_row;
    logic [NBANK-1:0][COL_W-1:0] req_col;
    logic [NBANK-1:0][SA_W-1:0]  bank_sa;
    sdram_cmd_e                  bank_cmd [NBANK];
    logic                        act_block;

    sdram_wb_port i_port (
        .clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_ack, .wb_dat_r,
        .push, .push_we, .push_adr, .push_dat, .full, .rd_valid, .rd_data
    );

    sdram_req_fifo i_fifo (
        .clk, .rst, .push, .push_we, .push_adr, .push_dat, .full,
        .pop, .empty, .head_we, .head_adr, .head_dat
    );

    for (genvar i = 0; i < NBANK; i++) begin : g_bank
        sdram_bank i_bank (
            .clk, .rst,
            .req(req[i]), .req_we(req_we[i]), .req_row(req_row[i]), .req_col(req_col[i]),
            .bg(bg[i]), .act_block, .br(br[i]), .issued(issued[i]),
            .cmd(bank_cmd[i]), .sa(bank_sa[i])
        );
    end

    sdram_cmd_seq i_seq (
        .clk, .rst, .empty, .head_we, .head_adr, .head_dat, .pop,
        .req, .req_we, .req_row, .req_col, .br, .issued,
        .cmd(bank_cmd), .sa(bank_sa), .bg, .act_block,
        .sdram_cmd, .sdram_ba, .sdram_a, .dq_out, .dq_oe, .dq_in,
        .rd_valid, .rd_data
    );

endmodule

//--- tb/tb_clk_gen.sv
`timescale 1ns/1ps
// testbench clock and power-on reset
// 10 ns period with reset high for the first 2 rising edges
module tb_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;    // 100 MHz
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;              // drops on the second rising edge
    end

endmodule

//--- tb/sdram_model.sv
`timescale 1ns/1ps
// behavioral SDR SDRAM for the testbench: four banks, CAS latency 2, burst of 1
// checks row state and tRP/tRCD/tRRD on each command and counts what it sees
module sdram_model (
    input  logic                         clk,
    input  logic                         rst,        // stands in for the init sequence
    input  sdram_pkg::sdram_cmd_e        cmd,
    input  logic [sdram_pkg::BANK_W-1:0] ba,
    input  logic [sdram_pkg::SA_W-1:0]   a,
    input  logic [sdram_pkg::DW-1:0]     dq_wr,
    input  logic                         dq_oe,
    output logic [sdram_pkg::DW-1:0]     dq_rd,
    output int                           proto_errs,
    output int                           n_prech,
    output int                           n_act
);
    import sdram_pkg::*;

    logic [DW-1:0]    mem [logic [WB_AW-1:0]];   // unwritten words read as zero
    logic [NBANK-1:0] open_q;                    // bank has a row open
    logic [ROW_W-1:0] open_row [NBANK];
    int               t_prech [NBANK];           // cycle of last PRECHARGE
    int               t_act [NBANK];             // cycle of last ACTIVE
    int               t_any_act;
    int               cyc_n = 0;
    int               errs = 0;
    int               precs = 0;
    int               acts = 0;
    logic [WB_AW-1:0] k;
    logic [DW-1:0]    rd_q;                      // first latency stage

    assign proto_errs = errs;
    assign n_prech    = precs;
    assign n_act      = acts;

    task automatic report(input string msg);
        $display("model error at cycle %0d: %s", cyc_n, msg);
        errs++;
    endtask

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            open_q    = '0;                       // all rows closed after init
            t_any_act = -100;
            for (int i = 0; i < NBANK; i++) begin
                t_prech[i] = -100;
                t_act[i]   = -100;
            end
            rd_q  <= '0;
            dq_rd <= '0;
        end else begin
            cyc_n++;
            dq_rd <= rd_q;                        // second stage onto dq
            case (cmd)
                CMD_ACTIVE: begin
                    acts++;
                    if (open_q[ba]) report($sformatf("ACTIVE to bank %0d, already open", ba));
                    if (cyc_n - t_any_act < T_RRD) report("ACTIVE too soon after ACTIVE");
                    if (cyc_n - t_prech[ba] < T_RP) report("ACTIVE too soon after PRECHARGE");
                    open_q[ba]   = 1'b1;
                    open_row[ba] = a[ROW_W-1:0];
                    t_act[ba]    = cyc_n;
                    t_any_act    = cyc_n;
                end
                CMD_PRECHARGE: begin
                    precs++;
                    if (a[10]) open_q = '0;       // precharge all
                    else       open_q[ba] = 1'b0;
                    t_prech[ba] = cyc_n;
                end
                CMD_READ, CMD_WRITE: begin
                    k = {ba, open_row[ba], a[COL_W-1:0]};
                    if (!open_q[ba]) begin
                        report($sformatf("%s to bank %0d with no open row", cmd.name(), ba));
                    end else begin
                        if (cyc_n - t_act[ba] < T_RCD) report("access too soon after ACTIVE");
                        if (a[10]) report("auto precharge bit set on access");
                        if (cmd == CMD_WRITE) begin
                            if (!dq_oe) report("WRITE with dq not driven");
                            mem[k] = dq_wr;
                        end else begin
                            rd_q <= mem.exists(k) ? mem[k] : '0;
                        end
                    end
                end
                default: ;                        // NOP
            endcase
        end
    end

endmodule

//--- tb/sdram_ctrl_tb.sv
`timescale 1ns/1ps
// top testbench: random wishbone traffic against a reference memory
// SDRAM model on the pins, closing line with error counts
module sdram_ctrl_tb;
    import sdram_pkg::*;

    localparam int ACK_TIMEOUT = 200;    // cycles, enough for a full queue of row misses

    logic             clk, rst_por, rst_mid, rst;
    logic             wb_cyc, wb_stb, wb_we, wb_ack;
    logic [WB_AW-1:0] wb_adr;
    logic [DW-1:0]    wb_dat_w, wb_dat_r;
    sdram_cmd_e       sdram_cmd;
    logic [BANK_W-1:0] sdram_ba;
    logic [SA_W-1:0]  sdram_a;
    logic [DW-1:0]    dq_out, dq_in;
    logic             dq_oe;
    int               proto_errs, n_prech, n_act;

    logic [DW-1:0]    ref_mem [logic [WB_AW-1:0]];   // last value written per address
    logic [WB_AW-1:0] written [$];
    int data_errs = 0;
    int cmd_errs = 0;
    int other_errs = 0;
    int timeouts = 0;

    assign rst = rst_por || rst_mid;    // power-on or mid-run

    tb_clk_gen i_clk (.clk, .rst(rst_por));

    sdram_ctrl_top i_dut (
        .clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_ack, .wb_dat_r,
        .sdram_cmd, .sdram_ba, .sdram_a, .dq_out, .dq_oe, .dq_in
    );

    sdram_model i_model (
        .clk, .rst, .cmd(sdram_cmd), .ba(sdram_ba), .a(sdram_a), .dq_wr(dq_out), .dq_oe,
        .dq_rd(dq_in), .proto_errs, .n_prech, .n_act
    );

    function automatic logic [WB_AW-1:0] make_adr(input logic [BANK_W-1:0] b,
                                                  input logic [ROW_W-1:0] r,
                                                  input logic [COL_W-1:0] c);
        return {b, r, c};    // bank on top
    endfunction

    task automatic check_data(input string name, input logic [DW-1:0] exp,
                              input logic [DW-1:0] act);
        if (act !== exp) begin
            $display("** Error [%s] expected %h actual %h", name, exp, act);
            data_errs++;
        end
    endtask

    task automatic check_cmd(input string name, input sdram_cmd_e exp, input sdram_cmd_e act);
        if (act !== exp) begin
            $display("** Error [%s] expected %s actual %s (%b)", name, exp.name(), act.name(), act);
            cmd_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error [%s] expected %b actual %b", name, exp, act);
            other_errs++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("** Error [%s] expected %0d actual %0d", name, exp, act);
            other_errs++;
        end
    endtask

    task automatic finish_run();
        int total;
        total = data_errs + cmd_errs + other_errs + timeouts + proto_errs;
        $display("errors: data %0d, command %0d, other %0d, model %0d, timeout %0d",
                 data_errs, cmd_errs, other_errs, proto_errs, timeouts);
        if (total == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    // pins idle and no ack while in reset
    task automatic reset_checks(input string name);
        check_cmd(name, CMD_NOP, sdram_cmd);
        check_flag(name, 1'b0, wb_ack);
    endtask

    // single classic cycle held until ack and sampled on the falling edge
    task automatic bus_cycle(input logic we, input logic [WB_AW-1:0] adr,
                             input logic [DW-1:0] dat, output logic [DW-1:0] rdat);
        int n;
        n = 0;
        rdat = '0;
        if (timeouts != 0) return;    // nothing more to run once the bus is stuck
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= dat;
        @(negedge clk);
        while (!wb_ack && n < ACK_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        rdat = wb_dat_r;
        if (!wb_ack) begin
            $display("timeout: no wb_ack for %s at address %h", we ? "write" : "read", adr);
            timeouts++;
        end
    endtask

    task automatic do_write(input logic [WB_AW-1:0] adr, input logic [DW-1:0] dat);
        logic [DW-1:0] unused;
        bus_cycle(1'b1, adr, dat, unused);
        ref_mem[adr] = dat;
        written.push_back(adr);
    endtask

    task automatic do_read(input string name, input logic [WB_AW-1:0] adr);
        logic [DW-1:0] got;
        bus_cycle(1'b0, adr, '0, got);
        if (timeouts == 0) begin
            check_data(name, ref_mem.exists(adr) ? ref_mem[adr] : '0, got);
        end
    endtask

    initial begin
        logic [WB_AW-1:0] adr;
        int n, n_p, n_a;
        void'($urandom(32'hf7b3));    // single seed for the run
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        rst_mid  = 1'b0;
        n = 0;
        @(negedge clk);
        while (rst && n < 10) begin
            reset_checks("power-on reset");
            @(negedge clk);
            n++;
        end
        if (rst) begin
            $display("timeout: power-on reset never released");
            timeouts++;
        end

        // t1 opens bank 0 from reset and reads the word back
        adr = make_adr(2'd0, 12'h123, 8'h45);
        do_write(adr, 16'hbeef);
        do_read("t1 write-read", adr);

        // t2 stays in one row of bank 1 so only hits follow the first ACTIVE
        do_write(make_adr(2'd1, 12'h055, 8'h00), DW'($urandom));
        n_p = n_prech;
        repeat (30) begin
            adr = make_adr(2'd1, 12'h055, COL_W'($urandom % 16));
            if ($urandom % 2) do_write(adr, DW'($urandom));
            else              do_read("t2 row hit", adr);
        end
        if (timeouts == 0) begin
            check_count("t2 PRECHARGE on row hits", 0, n_prech - n_p);
        end

        // t3 all banks and few rows so both hits and misses show up
        repeat (80) begin
            if (written.size() > 0 && ($urandom % 2)) begin
                do_read("t3 random", written[$urandom % written.size()]);
            end else begin
                adr = make_adr(BANK_W'($urandom), ROW_W'($urandom % 4), COL_W'($urandom % 16));
                do_write(adr, DW'($urandom));
            end
        end

        // t4 posted writes back to back over 5 reused addresses so later ones win
        for (int i = 0; i < 3 * FIFO_DEPTH; i++) begin
            adr = make_adr(BANK_W'(i % 5), ROW_W'(i % 5 + 7), COL_W'(i % 5));
            do_write(adr, DW'($urandom));
        end
        for (int i = 0; i < 5; i++) begin
            do_read("t4 posted order", make_adr(BANK_W'(i), ROW_W'(i + 7), COL_W'(i)));
        end

        // t5 reset with writes still queued so every bank starts closed afterwards
        for (int i = 0; i < 3; i++) begin
            do_write(make_adr(BANK_W'(i), 12'h0a0, COL_W'(i)), DW'($urandom));
        end
        @(posedge clk);
        wb_cyc  <= 1'b0;
        wb_stb  <= 1'b0;
        rst_mid <= 1'b1;
        repeat (2) begin
            @(negedge clk);
            reset_checks("t5 reset");
        end
        @(posedge clk);
        rst_mid <= 1'b0;
        n_p = n_prech;
        n_a = n_act;
        for (int i = 0; i < 3; i++) begin
            adr = make_adr(BANK_W'(i), 12'h0a0, COL_W'(i));
            do_write(adr, DW'($urandom));
            do_read("t5 after reset", adr);
        end
        if (timeouts == 0) begin
            check_count("t5 PRECHARGE after reset", 0, n_prech - n_p);
            check_count("t5 ACTIVE after reset", 3, n_act - n_a);
        end

        finish_run();
    end

endmodule

//--- files.f
verilog/sdram_pkg.sv
verilog/sdram_wb_port.sv
verilog/sdram_req_fifo.sv
verilog/sdram_bank.sv
verilog/sdram_cmd_seq.sv
verilog/sdram_ctrl_top.sv
tb/tb_clk_gen.sv
tb/sdram_model.sv
tb/sdram_ctrl_tb.sv
